// File: src/memStagePkg.sv
package memStagePkg;

    // data RAM geometry
    localparam int RAM_WORDS  = 256;
    localparam int RAM_ADDR_W = $clog2(RAM_WORDS);

    typedef logic [31:0]           word_t;
    typedef logic [4:0]            regAddr_t;
    typedef logic [3:0]            byteEn_t;
    typedef logic [RAM_ADDR_W-1:0] ramAddr_t;

    typedef enum logic [2:0] {
        LD_NONE = 3'd0,
        LD_B    = 3'd1,
        LD_BU   = 3'd2,
        LD_H    = 3'd3,
        LD_HU   = 3'd4,
        LD_W    = 3'd5
    } loadType_t;

    typedef enum logic [1:0] {
        ST_NONE = 2'd0,
        ST_B    = 2'd1,
        ST_H    = 2'd2,
        ST_W    = 2'd3
    } storeType_t;

    // misaligned load or store
    typedef enum logic [1:0] {
        EXC_NONE = 2'd0,
        EXC_ADEL = 2'd1,
        EXC_ADES = 2'd2
    } excCause_t;

    // contents of the EXE/MEM register
    typedef struct packed {
        word_t      pc;
        word_t      aluOut;
        word_t      storeData;
        byteEn_t    byteEn;
        loadType_t  loadType;
        regAddr_t   dst;
        logic       regWrite;
        excCause_t  excCause;
    } exeMemBus_t;

    // contents of the MEM/WB register
    typedef struct packed {
        word_t      pc;
        word_t      wbData;
        regAddr_t   dst;
        logic       regWrite;
    } memWbBus_t;

endpackage

// File: src/accessAlign.sv
`timescale 1ns/1ps

module accessAlign import memStagePkg::*; (
    input  word_t      addr,
    input  word_t      storeSrc,
    input  loadType_t  loadType,
    input  storeType_t storeType,
    output byteEn_t    byteEn,
    output word_t      storeData,
    output excCause_t  excCause
);

    logic halfBad;
    logic wordBad;
    logic loadBad;
    logic storeBad;

    assign halfBad  = addr[0];
    assign wordBad  = |addr[1:0];

    assign loadBad  = ((loadType == LD_H || loadType == LD_HU) && halfBad) ||
                      (loadType == LD_W && wordBad);
    assign storeBad = (storeType == ST_H && halfBad) || (storeType == ST_W && wordBad);

    always_comb begin
        if (loadBad) begin
            excCause = EXC_ADEL;
        end else if (storeBad) begin
            excCause = EXC_ADES;
        end else begin
            excCause = EXC_NONE;
        end
    end

    // little-endian lanes, nothing enabled on an address error
    always_comb begin
        byteEn = '0;
        if (!storeBad) begin
            case (storeType)
                ST_B:    byteEn = 4'b0001 << addr[1:0];
                ST_H:    byteEn = addr[1] ? 4'b1100 : 4'b0011;
                ST_W:    byteEn = 4'b1111;
                default: byteEn = '0;
            endcase
        end
    end

    // replicate so that every lane carries the operand
    always_comb begin
        case (storeType)
            ST_B:    storeData = {4{storeSrc[7:0]}};
            ST_H:    storeData = {2{storeSrc[15:0]}};
            default: storeData = storeSrc;
        endcase
    end

endmodule

// File: src/exeMemReg.sv
`timescale 1ns/1ps

module exeMemReg import memStagePkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       memWr,
    input  logic       memFlush,
    input  exeMemBus_t exeBus,
    output exeMemBus_t memBus
);

    // clear beats load, load beats hold
    always_ff @(posedge clk) begin
        if (rst || memFlush) begin
            memBus <= '0;
        end else if (memWr) begin
            memBus <= exeBus;
        end
    end

endmodule

// File: src/dataRam.sv
`timescale 1ns/1ps

module dataRam import memStagePkg::*; (
    input  logic     clk,
    input  ramAddr_t addr,
    input  byteEn_t  byteEn,
    input  logic     writeEn,
    input  word_t    wrData,
    output word_t    rdData
);

    word_t mem [RAM_WORDS];

    // per-lane write
    always_ff @(posedge clk) begin
        if (writeEn) begin
            for (int i = 0; i < 4; i++) begin
                if (byteEn[i]) begin
                    mem[addr][8*i +: 8] <= wrData[8*i +: 8];
                end
            end
        end
    end

    // asynchronous read, so a load in MEM sees data in the same cycle
    assign rdData = mem[addr];

endmodule

// File: src/loadAlign.sv
`timescale 1ns/1ps

module loadAlign import memStagePkg::*; (
    input  word_t     rdData,
    input  logic [1:0] addrLow,
    input  loadType_t loadType,
    input  word_t     aluOut,
    output word_t     wbData
);

    word_t shifted;

    // move the addressed lane down to bit 0
    assign shifted = rdData >> {addrLow, 3'b000};

    always_comb begin
        case (loadType)
            LD_B: begin
                wbData = {{24{shifted[7]}}, shifted[7:0]};
            end
            LD_BU: begin
                wbData = {24'b0, shifted[7:0]};
            end
            LD_H: begin
                wbData = {{16{shifted[15]}}, shifted[15:0]};
            end
            LD_HU: begin
                wbData = {16'b0, shifted[15:0]};
            end
            LD_W: begin
                wbData = rdData;
            end
            // not a load, so the ALU result goes to write-back
            default: begin
                wbData = aluOut;
            end
        endcase
    end

endmodule

// File: src/memWbReg.sv
`timescale 1ns/1ps

module memWbReg import memStagePkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      bubble,
    input  memWbBus_t memBus,
    output memWbBus_t wbBus
);

    // loads every cycle, a bubble only kills the register write
    always_ff @(posedge clk) begin
        if (rst) begin
            wbBus <= '0;
        end else begin
            wbBus          <= memBus;
            wbBus.regWrite <= memBus.regWrite && !bubble;
        end
    end

endmodule

// File: src/pipeCtrl.sv
`timescale 1ns/1ps

module pipeCtrl import memStagePkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      stall,
    input  logic      flush,
    input  excCause_t memExc,
    input  word_t     memPc,
    output logic      exeMemWr,
    output logic      exeMemFlush,
    output logic      ramWriteEn,
    output logic      memWbBubble,
    output logic      excValid,
    output word_t     excPc,
    output excCause_t excCause
);

    logic memHasExc;
    logic stalledLast;

    assign memHasExc   = (memExc != EXC_NONE);

    assign exeMemWr    = !stall;
    // an exception in MEM also squashes the instruction behind it
    assign exeMemFlush = flush || memHasExc;
    assign ramWriteEn  = !memHasExc;
    // held MEM item was already written back on the first stalled cycle
    assign memWbBubble = memHasExc || stalledLast;

    always_ff @(posedge clk) begin
        if (rst) begin
            stalledLast <= 1'b0;
            excValid    <= 1'b0;
            excCause    <= EXC_NONE;
        end else begin
            stalledLast <= stall;
            excValid    <= memHasExc;
            excCause    <= memExc;
        end
    end

    // pc of the faulting instruction, only meaningful with excValid
    always_ff @(posedge clk) begin
        excPc <= memPc;
    end

endmodule

// File: src/memStageTop.sv
`timescale 1ns/1ps

module memStageTop import memStagePkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       stall,
    input  logic       flush,
    input  word_t      exePc,
    input  word_t      exeAluOut,
    input  word_t      exeOutB,
    input  loadType_t  exeLoadType,
    input  storeType_t exeStoreType,
    input  regAddr_t   exeDst,
    input  logic       exeRegWrite,
    output logic       wbValid,
    output regAddr_t   wbDst,
    output word_t      wbData,
    output word_t      wbPc,
    output logic       excValid,
    output word_t      excPc,
    output excCause_t  excCause
);

    exeMemBus_t exeBus;
    exeMemBus_t memBus;
    memWbBus_t  memWbIn;
    memWbBus_t  wbBus;
    byteEn_t    exeByteEn;
    word_t      exeStoreData;
    excCause_t  exeExc;
    word_t      ramRdData;
    word_t      memWbData;
    logic       exeMemWr;
    logic       exeMemFlush;
    logic       ramWriteEn;
    logic       memWbBubble;

    accessAlign uAlign (
        .addr      (exeAluOut),
        .storeSrc  (exeOutB),
        .loadType  (exeLoadType),
        .storeType (exeStoreType),
        .byteEn    (exeByteEn),
        .storeData (exeStoreData),
        .excCause  (exeExc)
    );

    assign exeBus = '{
        pc:        exePc,
        aluOut:    exeAluOut,
        storeData: exeStoreData,
        byteEn:    exeByteEn,
        loadType:  exeLoadType,
        dst:       exeDst,
        regWrite:  exeRegWrite,
        excCause:  exeExc
    };

    exeMemReg uExeMem (
        .clk      (clk),
        .rst      (rst),
        .memWr    (exeMemWr),
        .memFlush (exeMemFlush),
        .exeBus   (exeBus),
        .memBus   (memBus)
    );

    dataRam uRam (
        .clk     (clk),
        .addr    (memBus.aluOut[RAM_ADDR_W+1:2]),
        .byteEn  (memBus.byteEn),
        .writeEn (ramWriteEn),
        .wrData  (memBus.storeData),
        .rdData  (ramRdData)
    );

    loadAlign uLoad (
        .rdData   (ramRdData),
        .addrLow  (memBus.aluOut[1:0]),
        .loadType (memBus.loadType),
        .aluOut   (memBus.aluOut),
        .wbData   (memWbData)
    );

    assign memWbIn = '{
        pc:       memBus.pc,
        wbData:   memWbData,
        dst:      memBus.dst,
        regWrite: memBus.regWrite
    };

    memWbReg uMemWb (
        .clk    (clk),
        .rst    (rst),
        .bubble (memWbBubble),
        .memBus (memWbIn),
        .wbBus  (wbBus)
    );

    pipeCtrl uCtrl (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .flush       (flush),
        .memExc      (memBus.excCause),
        .memPc       (memBus.pc),
        .exeMemWr    (exeMemWr),
        .exeMemFlush (exeMemFlush),
        .ramWriteEn  (ramWriteEn),
        .memWbBubble (memWbBubble),
        .excValid    (excValid),
        .excPc       (excPc),
        .excCause    (excCause)
    );

    assign wbValid = wbBus.regWrite;
    assign wbDst   = wbBus.dst;
    assign wbData  = wbBus.wbData;
    assign wbPc    = wbBus.pc;

endmodule

// File: verif/clkGen.sv
`timescale 1ns/1ps

module clkGen (
    output logic clk,
    output logic rst
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held for the first five edges
    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: verif/memStageTb.sv
`timescale 1ns/1ps

module memStageTb import memStagePkg::*; ();

    localparam int NUM_TESTS = 34;
    localparam int TIMEOUT   = NUM_TESTS + 20;

    typedef enum logic [3:0] {
        OP_ALU, OP_ALUNW, OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW
    } op_t;

    // a zero store operand in a table row means random data
    typedef struct packed {
        word_t     pc;
        op_t       op;
        word_t     addr;
        word_t     operand;
        regAddr_t  dst;
        logic      stall;
        logic      flush;
        excCause_t exc;
    } test_t;

    typedef struct packed {
        logic      wbValid;
        regAddr_t  dst;
        word_t     data;
        word_t     pc;
        logic      excValid;
        excCause_t cause;
    } result_t;

    localparam test_t IDLE_ENTRY = '{32'h0, OP_ALUNW, 32'h0, 32'h0, 5'd0, 1'b0, 1'b0, EXC_NONE};

    logic       clk;
    logic       rst;
    logic       stall;
    logic       flush;
    word_t      exePc;
    word_t      exeAluOut;
    word_t      exeOutB;
    loadType_t  exeLoadType;
    storeType_t exeStoreType;
    regAddr_t   exeDst;
    logic       exeRegWrite;
    logic       wbValid;
    regAddr_t   wbDst;
    word_t      wbData;
    word_t      wbPc;
    logic       excValid;
    word_t      excPc;
    excCause_t  excCause;

    test_t      tests [NUM_TESTS];
    result_t    pending [$];
    logic [7:0] memBytes [RAM_WORDS][4];
    logic       squashNext = 1'b0;
    int         errors = 0;
    int         cycles = 0;

    clkGen uClk (
        .clk (clk),
        .rst (rst)
    );

    memStageTop dut (.*);

    function automatic loadType_t loadKind(op_t op);
        case (op)
            OP_LB:   return LD_B;
            OP_LBU:  return LD_BU;
            OP_LH:   return LD_H;
            OP_LHU:  return LD_HU;
            OP_LW:   return LD_W;
            default: return LD_NONE;
        endcase
    endfunction

    function automatic storeType_t storeKind(op_t op);
        case (op)
            OP_SB:   return ST_B;
            OP_SH:   return ST_H;
            OP_SW:   return ST_W;
            default: return ST_NONE;
        endcase
    endfunction

    task automatic applyInputs(input test_t t, input word_t operand);
        stall        <= t.stall;
        flush        <= t.flush;
        exePc        <= t.pc;
        exeAluOut    <= t.addr;
        exeOutB      <= operand;
        exeLoadType  <= loadKind(t.op);
        exeStoreType <= storeKind(t.op);
        exeDst       <= t.dst;
        exeRegWrite  <= (t.op == OP_ALU) || (loadKind(t.op) != LD_NONE);
    endtask

    // works out the expected outcome of one entry and updates the byte model
    task automatic predictResult(input test_t t, input word_t operand, output result_t r);
        ramAddr_t    w;
        logic [1:0]  ln;
        logic [7:0]  b;
        logic [15:0] h;
        logic        entered;
        w  = t.addr[RAM_ADDR_W+1:2];
        ln = t.addr[1:0];
        b  = memBytes[w][ln];
        h  = {memBytes[w][{ln[1], 1'b1}], memBytes[w][{ln[1], 1'b0}]};
        r  = '0;
        r.pc  = t.pc;
        r.dst = t.dst;
        entered    = !t.stall && !t.flush && !squashNext;
        squashNext = 1'b0;
        if (entered && t.exc != EXC_NONE) begin
            // the entry right behind a fault is squashed
            r.excValid = 1'b1;
            r.cause    = t.exc;
            squashNext = 1'b1;
        end else if (entered) begin
            r.wbValid = (t.op == OP_ALU) || (loadKind(t.op) != LD_NONE);
            case (t.op)
                OP_ALU: r.data = t.addr;
                OP_LB:  r.data = {{24{b[7]}}, b};
                OP_LBU: r.data = {24'h0, b};
                OP_LH:  r.data = {{16{h[15]}}, h};
                OP_LHU: r.data = {16'h0, h};
                OP_LW:  r.data = {memBytes[w][2'd3], memBytes[w][2'd2],
                                  memBytes[w][2'd1], memBytes[w][2'd0]};
                OP_SB:  memBytes[w][ln] = operand[7:0];
                OP_SH: begin
                    memBytes[w][{ln[1], 1'b0}] = operand[7:0];
                    memBytes[w][{ln[1], 1'b1}] = operand[15:8];
                end
                OP_SW: begin
                    memBytes[w][2'd0] = operand[7:0];
                    memBytes[w][2'd1] = operand[15:8];
                    memBytes[w][2'd2] = operand[23:16];
                    memBytes[w][2'd3] = operand[31:24];
                end
                default: ;
            endcase
        end
    endtask

    task automatic checkValue(input string name, input word_t want, input word_t got,
                              input int idx);
        if (got !== want) begin
            errors++;
            $display("Error %s expected %h got %h at entry %0d", name, want, got, idx);
        end
    endtask

    // negative entries are the two cycles right after reset
    task automatic checkOutputs(input result_t r, input int idx);
        if (wbValid !== r.wbValid) begin
            errors++;
            $display("%s write-back for entry %0d", r.wbValid ? "missing" : "unexpected", idx);
        end else if (r.wbValid) begin
            checkValue("wbDst", word_t'(r.dst), word_t'(wbDst), idx);
            checkValue("wbData", r.data, wbData, idx);
            checkValue("wbPc", r.pc, wbPc, idx);
        end
        if (excValid !== r.excValid) begin
            errors++;
            $display("%s exception report for entry %0d",
                     r.excValid ? "missing" : "unexpected", idx);
        end else if (r.excValid) begin
            checkValue("excPc", r.pc, excPc, idx);
            checkValue("excCause", word_t'(r.cause), word_t'(excCause), idx);
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("run did not finish within %0d cycles", TIMEOUT);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        test_t   t;
        word_t   operand;
        result_t r;
        void'($urandom(32'h8646_dc04));
        applyInputs(IDLE_ENTRY, '0);
        tests = '{
            '{32'h400, OP_ALU,   32'h1234_5678, 32'h0,         5'd1,  1'b0, 1'b0, EXC_NONE},
            '{32'h404, OP_ALUNW, 32'hdead_beef, 32'h0,         5'd2,  1'b0, 1'b0, EXC_NONE},
            '{32'h408, OP_SW,    32'h10,        32'h0,         5'd0,  1'b0, 1'b0, EXC_NONE},
            '{32'h40c, OP_SW,    32'h14,        32'h8081_7f80, 5'd0,  1'b0, 1'b0, EXC_NONE},
            '{32'h410, OP_LW,    32'h14,        32'h0,         5'd3,  1'b0, 1'b0, EXC_NONE},
            '{32'h414, OP_LB,    32'h14,        32'h0,         5'd4,  1'b0, 1'b0, EXC_NONE},
            '{32'h418, OP_LBU,   32'h17,        32'h0,         5'd5,  1'b0, 1'b0, EXC_NONE},
            '{32'h41c, OP_LB,    32'h15,        32'h0,         5'd6,  1'b0, 1'b0, EXC_NONE},
            '{32'h420, OP_LH,    32'h16,        32'h0,         5'd7,  1'b0, 1'b0, EXC_NONE},
            '{32'h424, OP_LHU,   32'h16,        32'h0,         5'd8,  1'b0, 1'b0, EXC_NONE},
            '{32'h428, OP_SB,    32'h13,        32'h0,         5'd0,  1'b0, 1'b0, EXC_NONE},
            '{32'h42c, OP_LBU,   32'h13,        32'h0,         5'd9,  1'b0, 1'b0, EXC_NONE},
            '{32'h430, OP_SH,    32'h10,        32'h0,         5'd0,  1'b0, 1'b0, EXC_NONE},
            '{32'h434, OP_LW,    32'h10,        32'h0,         5'd10, 1'b0, 1'b0, EXC_NONE},
            '{32'h438, OP_SH,    32'h21,        32'h0000_ffff, 5'd0,  1'b0, 1'b0, EXC_ADES},
            '{32'h43c, OP_ALU,   32'h55,        32'h0,         5'd11, 1'b0, 1'b0, EXC_NONE},
            '{32'h440, OP_LW,    32'h22,        32'h0,         5'd12, 1'b0, 1'b0, EXC_ADEL},
            '{32'h444, OP_ALU,   32'h66,        32'h0,         5'd13, 1'b0, 1'b0, EXC_NONE},
            '{32'h448, OP_SW,    32'h16,        32'hffff_ffff, 5'd0,  1'b0, 1'b0, EXC_ADES},
            '{32'h44c, OP_LBU,   32'h14,        32'h0,         5'd14, 1'b0, 1'b0, EXC_NONE},
            '{32'h450, OP_LHU,   32'h13,        32'h0,         5'd15, 1'b0, 1'b0, EXC_ADEL},
            '{32'h454, OP_LW,    32'h14,        32'h0,         5'd16, 1'b0, 1'b0, EXC_NONE},
            '{32'h458, OP_LW,    32'h14,        32'h0,         5'd17, 1'b0, 1'b0, EXC_NONE},
            '{32'h45c, OP_SW,    32'h30,        32'h1111_2222, 5'd0,  1'b0, 1'b0, EXC_NONE},
            '{32'h460, OP_SW,    32'h30,        32'h3333_4444, 5'd0,  1'b0, 1'b1, EXC_NONE},
            '{32'h464, OP_LW,    32'h30,        32'h0,         5'd18, 1'b0, 1'b0, EXC_NONE},
            '{32'h468, OP_ALU,   32'h99,        32'h0,         5'd19, 1'b0, 1'b1, EXC_NONE},
            '{32'h46c, OP_SW,    32'h40,        32'h0,         5'd0,  1'b0, 1'b0, EXC_NONE},
            '{32'h470, OP_ALU,   32'h77,        32'h0,         5'd20, 1'b1, 1'b0, EXC_NONE},
            '{32'h474, OP_LW,    32'h40,        32'h0,         5'd21, 1'b0, 1'b0, EXC_NONE},
            '{32'h478, OP_ALU,   32'habc,       32'h0,         5'd22, 1'b0, 1'b0, EXC_NONE},
            '{32'h47c, OP_ALU,   32'hbad,       32'h0,         5'd23, 1'b1, 1'b0, EXC_NONE},
            '{32'h480, OP_ALU,   32'hbad,       32'h0,         5'd24, 1'b1, 1'b0, EXC_NONE},
            '{32'h484, OP_LH,    32'h10,        32'h0,         5'd25, 1'b0, 1'b0, EXC_NONE}
        };
        // nothing valid in the two cycles after reset
        pending.push_back('0);
        pending.push_back('0);
        @(negedge rst);
        for (int i = 0; i < NUM_TESTS + 2; i++) begin
            @(posedge clk);
            if (i < NUM_TESTS) begin
                t       = tests[i];
                operand = t.operand;
                if (storeKind(t.op) != ST_NONE && operand == '0) begin
                    operand = $urandom;
                end
                applyInputs(t, operand);
                predictResult(t, operand, r);
                pending.push_back(r);
            end else begin
                applyInputs(IDLE_ENTRY, '0);
            end
            // results show two cycles after the entry is presented
            @(negedge clk);
            checkOutputs(pending.pop_front(), i - 2);
        end
        $display("%0d errors in %0d entries", errors, NUM_TESTS);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
src/memStagePkg.sv
src/accessAlign.sv
src/exeMemReg.sv
src/dataRam.sv
src/loadAlign.sv
src/memWbReg.sv
src/pipeCtrl.sv
src/memStageTop.sv
verif/clkGen.sv
verif/memStageTb.sv

// File: run.sh
#!/bin/sh
# build and run the memory stage testbench, a failure line in the log fails the run
rm -f sim.log
verilator --binary --timing --top-module memStageTb -f verilog.f > sim.log 2>&1 &&
    ./obj_dir/VmemStageTb >> sim.log 2>&1 ||
    echo "Testbench failed" >> sim.log
cat sim.log
! grep -q "Testbench failed" sim.log
